// File: src.f
+incdir+.
dispatchPkg.sv
dispatchDecode.sv
resourceCheck.sv
dispatchRegister.sv
dispatchStage.sv
tb_dispatchStage.sv

// File: Bender.yml
package:
  name: dispatch_stage

sources:
  - dispatchPkg.sv
  - dispatchDecode.sv
  - resourceCheck.sv
  - dispatchRegister.sv
  - dispatchStage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dispatchStage.sv

// File: dispatchRefModel.svh
`ifndef DISPATCH_REF_MODEL_SVH
`define DISPATCH_REF_MODEL_SVH

// Expected decode of a renamed bundle
function automatic dispatchBundleT refDecode(input renamedBundleT bundle,
                                             input logic verified,
                                             input checkpointIdT verifiedId);
  dispatchBundleT result;
  for (int lane = 0; lane < DispatchWidth; lane++) begin
    result[lane].inst    = bundle[lane];
    result[lane].isLoad  = (bundle[lane].opcode == OP_LOAD);
    result[lane].isStore = (bundle[lane].opcode == OP_STORE);
    if (verified) begin
      result[lane].inst.branchMask = bundle[lane].branchMask & ~(8'h01 << verifiedId);
    end
  end
  return result;
endfunction

function automatic branchMaskBundleT refMasks(input dispatchBundleT bundle);
  branchMaskBundleT masks;
  for (int lane = 0; lane < DispatchWidth; lane++) begin
    masks[lane] = bundle[lane].inst.branchMask;
  end
  return masks;
endfunction

// Capacity rule evaluated in plain integers
function automatic logic refStall(input dispatchBundleT bundle, input int unsigned lq,
                                  input int unsigned sq, input int unsigned iq,
                                  input int unsigned al);
  int unsigned loads;
  int unsigned stores;
  loads  = 0;
  stores = 0;
  for (int lane = 0; lane < DispatchWidth; lane++) begin
    loads  += bundle[lane].isLoad;
    stores += bundle[lane].isStore;
  end
  return (lq + loads > LsqSize) || (sq + stores > LsqSize) ||
         (iq + DispatchWidth > IssueQueueSize) || (al + DispatchWidth > ActiveListSize);
endfunction

function automatic logic refReady(input logic renameReady, input logic recover,
                                  input logic stall);
  return renameReady && !recover && !stall;
endfunction

function automatic issueqBundleT refIssueq(input dispatchBundleT bundle);
  issueqBundleT result;
  for (int lane = 0; lane < DispatchWidth; lane++) begin
    result[lane] = '{bundle[lane].inst.pc, bundle[lane].inst.opcode,
                     bundle[lane].inst.src1, bundle[lane].inst.src2,
                     bundle[lane].inst.physDest, bundle[lane].inst.immediate,
                     bundle[lane].inst.branchMask, bundle[lane].inst.checkpointId};
  end
  return result;
endfunction

function automatic alBundleT refAl(input dispatchBundleT bundle);
  alBundleT result;
  for (int lane = 0; lane < DispatchWidth; lane++) begin
    result[lane] = '{bundle[lane].isLoad, bundle[lane].isStore, bundle[lane].inst.pc,
                     bundle[lane].inst.logicalDest, bundle[lane].inst.physDest,
                     bundle[lane].inst.oldPhysDest};
  end
  return result;
endfunction

function automatic lsqBundleT refLsq(input dispatchBundleT bundle);
  lsqBundleT result;
  for (int lane = 0; lane < DispatchWidth; lane++) begin
    result[lane] = '{bundle[lane].inst.branchMask, bundle[lane].isStore, bundle[lane].isLoad};
  end
  return result;
endfunction

`endif

// File: tb_dispatchStage.sv
`timescale 1ns/1ps

module tb_dispatchStage
  import dispatchPkg::*;
();

  localparam int unsigned TimeoutCycles = 2000;  // Six tests of up to 300 cycles plus reset

  logic               clk;
  logic               arstN;
  logic               renameReady;
  logic               flagRecoverEX;
  logic               ctrlVerified;
  checkpointIdT       ctrlVerifiedId;
  renamedBundleT      renamedBundle;
  logic [LsqCntW-1:0] loadQueueCnt;
  logic [LsqCntW-1:0] storeQueueCnt;
  logic [IqCntW-1:0]  issueQueueCnt;
  logic [AlCntW-1:0]  activeListCnt;
  logic               backEndReady;
  logic               stallFrontEnd;
  branchMaskBundleT   updatedBranchMask;
  logic               dispatchValid;
  issueqBundleT       issueqBundle;
  alBundleT           alBundle;
  lsqBundleT          lsqBundle;

  int unsigned        checkCnt = 0;
  int unsigned        errCnt = 0;
  int unsigned        cycleCnt = 0;
  logic               expValid = 1'b0;  // A bundle was accepted at the last edge
  dispatchBundleT     expHeld;          // Last accepted bundle as it should decode

  dispatchStage dispatchStage_inst (
    .clk                 (clk),
    .arstN_i             (arstN),
    .renameReady_i       (renameReady),
    .flagRecoverEX_i     (flagRecoverEX),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .renamedBundle_i     (renamedBundle),
    .loadQueueCnt_i      (loadQueueCnt),
    .storeQueueCnt_i     (storeQueueCnt),
    .issueQueueCnt_i     (issueQueueCnt),
    .activeListCnt_i     (activeListCnt),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd),
    .updatedBranchMask_o (updatedBranchMask),
    .dispatchValid_o     (dispatchValid),
    .issueqBundle_o      (issueqBundle),
    .alBundle_o          (alBundle),
    .lsqBundle_o         (lsqBundle)
  );

  `include "dispatchRefModel.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [511:0] got,
                            input logic [511:0] exp);
    checkCnt++;
    if (got !== exp) begin
      errCnt++;
      $display("Mismatch %s at %0t: got %0h expected %0h", name, $time, got, exp);
    end
  endtask

  function automatic renamedBundleT randomBundle();
    renamedBundleT bundle;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      bundle[lane].pc           = $urandom;
      bundle[lane].opcode       = opcodeT'($urandom_range(3));
      bundle[lane].logicalDest  = LogRegW'($urandom);
      bundle[lane].physDest     = PhysRegW'($urandom);
      bundle[lane].oldPhysDest  = PhysRegW'($urandom);
      bundle[lane].src1         = PhysRegW'($urandom);
      bundle[lane].src2         = PhysRegW'($urandom);
      bundle[lane].immediate    = ImmW'($urandom);
      bundle[lane].branchMask   = branchMaskT'($urandom);
      bundle[lane].checkpointId = checkpointIdT'($urandom);
    end
    return bundle;
  endfunction

  function automatic int unsigned countOpcode(input renamedBundleT bundle, input opcodeT op);
    int unsigned hits;
    hits = 0;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      if (bundle[lane].opcode == op) begin
        hits++;
      end
    end
    return hits;
  endfunction

  // One rising edge worth of stimulus
  task automatic driveCycle(input renamedBundleT bundle, input logic ready,
                            input logic recover, input logic verified,
                            input checkpointIdT verifiedId, input int unsigned lq,
                            input int unsigned sq, input int unsigned iq,
                            input int unsigned al);
    @(posedge clk);
    renamedBundle  <= bundle;
    renameReady    <= ready;
    flagRecoverEX  <= recover;
    ctrlVerified   <= verified;
    ctrlVerifiedId <= verifiedId;
    loadQueueCnt   <= LsqCntW'(lq);
    storeQueueCnt  <= LsqCntW'(sq);
    issueQueueCnt  <= IqCntW'(iq);
    activeListCnt  <= AlCntW'(al);
  endtask

  // Offer one bundle at given occupancies, then idle to see whether it went through
  task automatic runLimitCase(input renamedBundleT bundle, input int unsigned lq,
                              input int unsigned sq, input int unsigned iq,
                              input int unsigned al, input logic overLimit);
    driveCycle(bundle, 1'b1, 1'b0, 1'b0, '0, lq, sq, iq, al);
    @(negedge clk);
    checkValue("stallFrontEnd_o", stallFrontEnd, overLimit);
    checkValue("backEndReady_o", backEndReady, !overLimit);
    driveCycle(bundle, 1'b0, 1'b0, 1'b0, '0, 0, 0, 0, 0);
    @(negedge clk);
    checkValue("dispatchValid_o", dispatchValid, !overLimit);
  endtask

  task automatic reportTest(input string name, input int unsigned errStart);
    $display("Test %-14s %0d errors", name, errCnt - errStart);
  endtask

  task automatic resetBehavior();
    // Rename offers bundles late in reset, nothing may come out
    for (int i = 0; i < 8; i++) begin
      driveCycle(randomBundle(), i >= 4, 1'b0, 1'b0, '0, 0, 0, 0, 0);
      @(negedge clk);
      checkValue("dispatchValid_o", dispatchValid, 1'b0);
    end
    @(posedge clk);
    arstN       <= 1'b1;
    renameReady <= 1'b0;
    for (int i = 0; i < 10; i++) begin
      driveCycle(randomBundle(), 1'b0, 1'b0, 1'b0, '0, 0, 0, 0, 0);
      @(negedge clk);
      checkValue("backEndReady_o", backEndReady, 1'b0);
      checkValue("dispatchValid_o", dispatchValid, 1'b0);
    end
  endtask

  task automatic packetSplit();
    for (int i = 0; i < 60; i++) begin
      driveCycle(randomBundle(), $urandom_range(3) != 0, 1'b0, 1'b0, '0, 0, 0, 0, 0);
    end
    driveCycle(randomBundle(), 1'b0, 1'b0, 1'b0, '0, 0, 0, 0, 0);
    @(negedge clk);
  endtask

  task automatic lsqCapacity();
    renamedBundleT bundle;
    int unsigned   loads;
    int unsigned   stores;
    for (int i = 0; i < 20; i++) begin
      bundle = randomBundle();
      loads  = countOpcode(bundle, OP_LOAD);
      stores = countOpcode(bundle, OP_STORE);
      runLimitCase(bundle, LsqSize - loads, 0, 0, 0, 1'b0);
      runLimitCase(bundle, LsqSize - loads + 1, 0, 0, 0, 1'b1);
      runLimitCase(bundle, 0, LsqSize - stores, 0, 0, 1'b0);
      runLimitCase(bundle, 0, LsqSize - stores + 1, 0, 0, 1'b1);
    end
  endtask

  task automatic iqAlCapacity();
    renamedBundleT bundle;
    for (int i = 0; i < 10; i++) begin
      bundle = randomBundle();
      runLimitCase(bundle, 0, 0, IssueQueueSize - DispatchWidth, 0, 1'b0);
      runLimitCase(bundle, 0, 0, IssueQueueSize - DispatchWidth + 1, 0, 1'b1);
      runLimitCase(bundle, 0, 0, 0, ActiveListSize - DispatchWidth, 1'b0);
      runLimitCase(bundle, 0, 0, 0, ActiveListSize - DispatchWidth + 1, 1'b1);
    end
  endtask

  task automatic branchVerify();
    renamedBundleT    bundle;
    checkpointIdT     id;
    branchMaskBundleT lastMasks;
    branchMaskBundleT masks;
    for (int i = 0; i <= 40; i++) begin
      bundle = randomBundle();
      id     = checkpointIdT'($urandom_range(NumCheckpoints - 1));
      driveCycle(bundle, i < 40, 1'b0, 1'b1, id, 0, 0, 0, 0);
      @(negedge clk);
      for (int lane = 0; lane < DispatchWidth; lane++) begin
        masks[lane] = bundle[lane].branchMask & ~(branchMaskT'(1) << id);
        checkValue($sformatf("updatedBranchMask_o[%0d]", lane), updatedBranchMask[lane],
                   masks[lane]);
        if (i > 0) begin  // Previous bundle is now in the packets
          checkValue($sformatf("issueqBundle_o[%0d].branchMask", lane),
                     issueqBundle[lane].branchMask, lastMasks[lane]);
          checkValue($sformatf("lsqBundle_o[%0d].branchMask", lane),
                     lsqBundle[lane].branchMask, lastMasks[lane]);
        end
      end
      lastMasks = masks;
    end
  endtask

  task automatic recoveryHold();
    for (int i = 0; i < 40; i++) begin
      driveCycle(randomBundle(), 1'b1, 1'b1, 1'b0, '0, $urandom_range(LsqSize),
                 $urandom_range(LsqSize), $urandom_range(IssueQueueSize),
                 $urandom_range(ActiveListSize));
      @(negedge clk);
      checkValue("backEndReady_o", backEndReady, 1'b0);
      if (i > 0) begin
        checkValue("dispatchValid_o", dispatchValid, 1'b0);
      end
    end
  endtask

  // Every cycle, outputs are set against the reference, mid-cycle when they are stable
  always @(negedge clk) begin : compareOutputs
    dispatchBundleT decoded;
    logic           expStall;
    logic           expReady;
    if (!arstN) begin
      checkValue("dispatchValid_o", dispatchValid, 1'b0);
      checkValue("issueqBundle_o", issueqBundle, '0);
      checkValue("alBundle_o", alBundle, '0);
      checkValue("lsqBundle_o", lsqBundle, '0);
      expValid = 1'b0;
      expHeld  = '0;
    end else begin
      decoded  = refDecode(renamedBundle, ctrlVerified, ctrlVerifiedId);
      expStall = refStall(decoded, loadQueueCnt, storeQueueCnt, issueQueueCnt, activeListCnt);
      expReady = refReady(renameReady, flagRecoverEX, expStall);
      checkValue("stallFrontEnd_o", stallFrontEnd, expStall);
      checkValue("backEndReady_o", backEndReady, expReady);
      checkValue("updatedBranchMask_o", updatedBranchMask, refMasks(decoded));
      checkValue("dispatchValid_o", dispatchValid, expValid);
      // Packets keep the last accepted bundle through back-pressure
      checkValue("issueqBundle_o", issueqBundle, refIssueq(expHeld));
      checkValue("alBundle_o", alBundle, refAl(expHeld));
      checkValue("lsqBundle_o", lsqBundle, refLsq(expHeld));
      expValid = expReady;
      if (expReady) begin
        expHeld = decoded;
      end
    end
  end

  initial begin
    while (cycleCnt < TimeoutCycles) begin
      @(posedge clk);
      cycleCnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : stimulus
    int unsigned seedVal;
    int unsigned errStart;
    seedVal        = $urandom(47);
    arstN          = 1'b0;
    renameReady    = 1'b0;
    flagRecoverEX  = 1'b0;
    ctrlVerified   = 1'b0;
    ctrlVerifiedId = '0;
    renamedBundle  = '0;
    loadQueueCnt   = '0;
    storeQueueCnt  = '0;
    issueQueueCnt  = '0;
    activeListCnt  = '0;

    errStart = errCnt;
    resetBehavior();
    reportTest("reset", errStart);
    errStart = errCnt;
    packetSplit();
    reportTest("packet split", errStart);
    errStart = errCnt;
    lsqCapacity();
    reportTest("lsq capacity", errStart);
    errStart = errCnt;
    iqAlCapacity();
    reportTest("iq/al capacity", errStart);
    errStart = errCnt;
    branchVerify();
    reportTest("branch verify", errStart);
    errStart = errCnt;
    recoveryHold();
    reportTest("recovery", errStart);

    $display("Summary: %0d checks, %0d errors", checkCnt, errCnt);
    if (errCnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: dispatchStage.sv
`timescale 1ns/1ps

module dispatchStage
  import dispatchPkg::*;
(
  input  logic               clk,
  input  logic               arstN_i,
  input  logic               renameReady_i,
  input  logic               flagRecoverEX_i,
  input  logic               ctrlVerified_i,
  input  checkpointIdT       ctrlVerifiedId_i,
  input  renamedBundleT      renamedBundle_i,
  input  logic [LsqCntW-1:0] loadQueueCnt_i,
  input  logic [LsqCntW-1:0] storeQueueCnt_i,
  input  logic [IqCntW-1:0]  issueQueueCnt_i,
  input  logic [AlCntW-1:0]  activeListCnt_i,
  output logic               backEndReady_o,       // Bundle taken at this edge
  output logic               stallFrontEnd_o,      // Rename must hold its bundle
  output branchMaskBundleT   updatedBranchMask_o,  // Written back into the held bundle
  output logic               dispatchValid_o,
  output issueqBundleT       issueqBundle_o,
  output alBundleT           alBundle_o,
  output lsqBundleT          lsqBundle_o
);

  dispatchBundleT      decodedBundle;
  logic [LaneCntW-1:0] loadCnt;
  logic [LaneCntW-1:0] storeCnt;

  dispatchDecode dispatchDecode_inst (
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .renamedBundle_i  (renamedBundle_i),
    .decodedBundle_o  (decodedBundle),
    .loadCnt_o        (loadCnt),
    .storeCnt_o       (storeCnt)
  );

  resourceCheck resourceCheck_inst (
    .renameReady_i   (renameReady_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .loadCnt_i       (loadCnt),
    .storeCnt_i      (storeCnt),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .stallFrontEnd_o (stallFrontEnd_o),
    .backEndReady_o  (backEndReady_o)
  );

  // Ready doubles as the capture enable
  dispatchRegister dispatchRegister_inst (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .dispatchEn_i    (backEndReady_o),
    .decodedBundle_i (decodedBundle),
    .dispatchValid_o (dispatchValid_o),
    .issueqBundle_o  (issueqBundle_o),
    .alBundle_o      (alBundle_o),
    .lsqBundle_o     (lsqBundle_o)
  );

  for (genvar lane = 0; lane < DispatchWidth; lane++) begin : genMaskOut
    assign updatedBranchMask_o[lane] = decodedBundle[lane].inst.branchMask;
  end

endmodule

// File: dispatchRegister.sv
`timescale 1ns/1ps

module dispatchRegister
  import dispatchPkg::*;
(
  input  logic           clk,
  input  logic           arstN_i,
  input  logic           dispatchEn_i,     // Bundle accepted this cycle
  input  dispatchBundleT decodedBundle_i,
  output logic           dispatchValid_o,  // Packets below are new this cycle
  output issueqBundleT   issueqBundle_o,
  output alBundleT       alBundle_o,
  output lsqBundleT      lsqBundle_o
);

  dispatchBundleT heldBundle;

  // Valid lasts one cycle per accepted bundle
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      dispatchValid_o <= 1'b0;
    end else begin
      dispatchValid_o <= dispatchEn_i;
    end
  end

  // Packets read as zero until the first bundle lands
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      heldBundle <= '0;
    end else if (dispatchEn_i) begin
      heldBundle <= decodedBundle_i;
    end
  end

  // Issue queue gets what it needs to wake up and execute
  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      issueqBundle_o[lane].pc           = heldBundle[lane].inst.pc;
      issueqBundle_o[lane].opcode       = heldBundle[lane].inst.opcode;
      issueqBundle_o[lane].src1         = heldBundle[lane].inst.src1;
      issueqBundle_o[lane].src2         = heldBundle[lane].inst.src2;
      issueqBundle_o[lane].physDest     = heldBundle[lane].inst.physDest;
      issueqBundle_o[lane].immediate    = heldBundle[lane].inst.immediate;
      issueqBundle_o[lane].branchMask   = heldBundle[lane].inst.branchMask;
      issueqBundle_o[lane].checkpointId = heldBundle[lane].inst.checkpointId;
    end
  end

  // Active list keeps the mapping needed for retire and rollback
  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      alBundle_o[lane].isLoad      = heldBundle[lane].isLoad;
      alBundle_o[lane].isStore     = heldBundle[lane].isStore;
      alBundle_o[lane].pc          = heldBundle[lane].inst.pc;
      alBundle_o[lane].logicalDest = heldBundle[lane].inst.logicalDest;
      alBundle_o[lane].physDest    = heldBundle[lane].inst.physDest;
      alBundle_o[lane].oldPhysDest = heldBundle[lane].inst.oldPhysDest;
    end
  end

  // LSQ only allocates for memory lanes but sees every lane
  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      lsqBundle_o[lane].branchMask = heldBundle[lane].inst.branchMask;
      lsqBundle_o[lane].isStore    = heldBundle[lane].isStore;
      lsqBundle_o[lane].isLoad     = heldBundle[lane].isLoad;
    end
  end

endmodule

// File: resourceCheck.sv
`timescale 1ns/1ps

module resourceCheck
  import dispatchPkg::*;
(
  input  logic                renameReady_i,    // Rename holds a full bundle
  input  logic                flagRecoverEX_i,  // Mispredict recovery in progress
  input  logic [LaneCntW-1:0] loadCnt_i,
  input  logic [LaneCntW-1:0] storeCnt_i,
  input  logic [LsqCntW-1:0]  loadQueueCnt_i,
  input  logic [LsqCntW-1:0]  storeQueueCnt_i,
  input  logic [IqCntW-1:0]   issueQueueCnt_i,
  input  logic [AlCntW-1:0]   activeListCnt_i,
  output logic                stallFrontEnd_o,
  output logic                backEndReady_o
);

  // Projected occupancies, one bit wider so the sum cannot wrap
  logic [LsqCntW:0] loadSum;
  logic [LsqCntW:0] storeSum;
  logic [IqCntW:0]  issueSum;
  logic [AlCntW:0]  alSum;
  logic             loadFull;
  logic             storeFull;
  logic             issueFull;
  logic             alFull;

  assign loadSum  = {1'b0, loadQueueCnt_i} + (LsqCntW + 1)'(loadCnt_i);
  assign storeSum = {1'b0, storeQueueCnt_i} + (LsqCntW + 1)'(storeCnt_i);
  // Every lane takes an issue queue slot and an active list slot
  assign issueSum = {1'b0, issueQueueCnt_i} + (IqCntW + 1)'(DispatchWidth);
  assign alSum    = {1'b0, activeListCnt_i} + (AlCntW + 1)'(DispatchWidth);

  assign loadFull  = (loadSum > (LsqCntW + 1)'(LsqSize));
  assign storeFull = (storeSum > (LsqCntW + 1)'(LsqSize));
  assign issueFull = (issueSum > (IqCntW + 1)'(IssueQueueSize));
  assign alFull    = (alSum > (AlCntW + 1)'(ActiveListSize));

  // Stall depends on capacity alone so rename keeps its bundle during recovery too
  assign stallFrontEnd_o = loadFull | storeFull | issueFull | alFull;
  assign backEndReady_o  = renameReady_i & ~flagRecoverEX_i & ~stallFrontEnd_o;

endmodule

// File: dispatchDecode.sv
`timescale 1ns/1ps

module dispatchDecode
  import dispatchPkg::*;
(
  input  logic                ctrlVerified_i,    // A branch resolved correctly
  input  checkpointIdT        ctrlVerifiedId_i,  // Its checkpoint
  input  renamedBundleT       renamedBundle_i,
  output dispatchBundleT      decodedBundle_o,
  output logic [LaneCntW-1:0] loadCnt_o,
  output logic [LaneCntW-1:0] storeCnt_o
);

  // The verified branch no longer guards any lane, so its bit is dropped
  // from every mask before the bundle goes anywhere
  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      decodedBundle_o[lane].inst    = renamedBundle_i[lane];
      decodedBundle_o[lane].isLoad  = (renamedBundle_i[lane].opcode == OP_LOAD);
      decodedBundle_o[lane].isStore = (renamedBundle_i[lane].opcode == OP_STORE);
      if (ctrlVerified_i) begin
        decodedBundle_o[lane].inst.branchMask[ctrlVerifiedId_i] = 1'b0;
      end
    end
  end

  // Memory operations in this bundle
  always_comb begin
    loadCnt_o  = '0;
    storeCnt_o = '0;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      loadCnt_o  = loadCnt_o + LaneCntW'(decodedBundle_o[lane].isLoad);
      storeCnt_o = storeCnt_o + LaneCntW'(decodedBundle_o[lane].isStore);
    end
  end

endmodule

// File: dispatchPkg.sv
package dispatchPkg;

  // Machine widths
  localparam int unsigned DispatchWidth  = 4;   // Lanes per bundle
  localparam int unsigned NumCheckpoints = 8;   // Branch checkpoints
  localparam int unsigned CheckpointIdW  = 3;
  localparam int unsigned PcW            = 32;
  localparam int unsigned LogRegW        = 5;   // Architectural register index
  localparam int unsigned PhysRegW       = 7;   // Physical register tag
  localparam int unsigned ImmW           = 16;

  // Back-end structure capacities
  localparam int unsigned LsqSize        = 16;  // Entries in each of load and store queue
  localparam int unsigned IssueQueueSize = 32;
  localparam int unsigned ActiveListSize = 96;

  // Occupancy counters carry one extra bit so a full structure is representable
  localparam int unsigned LsqCntW  = $clog2(LsqSize) + 1;
  localparam int unsigned IqCntW   = $clog2(IssueQueueSize) + 1;
  localparam int unsigned AlCntW   = $clog2(ActiveListSize) + 1;
  localparam int unsigned LaneCntW = 3;         // Holds 0 to DispatchWidth

  typedef enum logic [1:0] {
    OP_ALU    = 2'd0,
    OP_LOAD   = 2'd1,
    OP_STORE  = 2'd2,
    OP_BRANCH = 2'd3
  } opcodeT;

  // One bit per unresolved branch the instruction depends on
  typedef logic [NumCheckpoints-1:0] branchMaskT;
  typedef logic [CheckpointIdW-1:0]  checkpointIdT;

  // Instruction as it leaves rename
  typedef struct packed {
    logic [PcW-1:0]      pc;
    opcodeT              opcode;
    logic [LogRegW-1:0]  logicalDest;
    logic [PhysRegW-1:0] physDest;
    logic [PhysRegW-1:0] oldPhysDest;   // Freed when the instruction retires
    logic [PhysRegW-1:0] src1;
    logic [PhysRegW-1:0] src2;
    logic [ImmW-1:0]     immediate;
    branchMaskT          branchMask;
    checkpointIdT        checkpointId;  // Checkpoint taken by a branch
  } renamedInstT;

  // Renamed instruction with its memory flags resolved
  typedef struct packed {
    renamedInstT inst;
    logic        isLoad;
    logic        isStore;
  } dispatchInstT;

  typedef struct packed {
    logic [PcW-1:0]      pc;
    opcodeT              opcode;
    logic [PhysRegW-1:0] src1;
    logic [PhysRegW-1:0] src2;
    logic [PhysRegW-1:0] physDest;
    logic [ImmW-1:0]     immediate;
    branchMaskT          branchMask;
    checkpointIdT        checkpointId;
  } issueqEntryT;

  typedef struct packed {
    logic                isLoad;
    logic                isStore;
    logic [PcW-1:0]      pc;
    logic [LogRegW-1:0]  logicalDest;
    logic [PhysRegW-1:0] physDest;
    logic [PhysRegW-1:0] oldPhysDest;
  } alEntryT;

  typedef struct packed {
    branchMaskT branchMask;
    logic       isStore;
    logic       isLoad;
  } lsqEntryT;

  // Whole bundles, lane 0 in the low slot
  typedef renamedInstT  [DispatchWidth-1:0] renamedBundleT;
  typedef dispatchInstT [DispatchWidth-1:0] dispatchBundleT;
  typedef issueqEntryT  [DispatchWidth-1:0] issueqBundleT;
  typedef alEntryT      [DispatchWidth-1:0] alBundleT;
  typedef lsqEntryT     [DispatchWidth-1:0] lsqBundleT;
  typedef branchMaskT   [DispatchWidth-1:0] branchMaskBundleT;

endpackage
